//--- include/mul_consts.svh
// Multiplier constants for the operand width and the default array core depth

`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Width of one operand and of the returned result word
`define MUL_DATA_WIDTH 32

// Default number of register groups inside the array core
// The whole unit adds one operand register and one result register
`define MUL_CORE_STAGES 2

`endif

//--- rtl/mul_array_core.sv
// Array core that multiplies magnitudes in pipelined row groups with the sideband in lock step

`timescale 1ns/1ps

`include "mul_consts.svh"

module mul_array_core
    import mul_pkg::*;
#(
    // The number of register groups ranges from 1 to the data width
    parameter int CORE_STAGES = `MUL_CORE_STAGES
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       clear_i,
    mul_operand_if.dst in_i,
    mul_product_if.src out_o
);

    localparam int W = `MUL_DATA_WIDTH;

    // ========================================
    // Pipeline boundaries
    // ========================================

    // Index 0 is the incoming item and index s+1 is the register after group s
    logic       valid_p  [CORE_STAGES+1];
    mul_uop_t   op_p     [CORE_STAGES+1];
    logic       negate_p [CORE_STAGES+1];
    product_t   psum_p   [CORE_STAGES+1];

    // Operands are only needed up to the input of the last group
    data_word_t mcand_p  [CORE_STAGES];
    data_word_t mplier_p [CORE_STAGES];

    assign valid_p[0]  = in_i.valid;
    assign op_p[0]     = in_i.op;
    assign negate_p[0] = in_i.negate;
    assign mcand_p[0]  = in_i.multiplicand;
    assign mplier_p[0] = in_i.multiplier;

    // The first group starts from an empty partial sum
    assign psum_p[0] = '0;

    // ========================================
    // Row groups
    // ========================================

    for (genvar s = 0; s < CORE_STAGES; s++) begin : g_stage
        // Rows are spread as evenly as the integer division allows
        localparam int ROW_LO = (s * W) / CORE_STAGES;
        localparam int ROW_HI = ((s + 1) * W) / CORE_STAGES;

        product_t group_sum;

        // Carry-propagate chain over this group's shifted partial-product rows
        // Row r is the multiplicand shifted by r, gated by multiplier bit r
        always_comb begin : row_adder
            group_sum = psum_p[s];
            for (int r = ROW_LO; r < ROW_HI; r++) begin
                if (mplier_p[s][r]) begin
                    group_sum = group_sum + (product_t'(mcand_p[s]) << r);
                end
            end
        end : row_adder

        // The valid chain is cleared by reset and by the pipeline clear
        always_ff @(posedge clk_i) begin : valid_reg
            if (!rst_n_i) begin
                valid_p[s+1] <= 1'b0;
            end else if (clear_i) begin
                valid_p[s+1] <= 1'b0;
            end else if (clk_en_i) begin
                valid_p[s+1] <= valid_p[s];
            end
        end : valid_reg

        // Partial sum and sideband advance together
        always_ff @(posedge clk_i) begin : sum_reg
            if (clk_en_i) begin
                op_p[s+1]     <= op_p[s];
                negate_p[s+1] <= negate_p[s];
                psum_p[s+1]   <= group_sum;
            end
        end : sum_reg

        // Later groups still need both operands for their own rows
        if (s < CORE_STAGES - 1) begin : g_operand_fwd
            always_ff @(posedge clk_i) begin : operand_reg
                if (clk_en_i) begin
                    mcand_p[s+1]  <= mcand_p[s];
                    mplier_p[s+1] <= mplier_p[s];
                end
            end : operand_reg
        end
    end

    // ========================================
    // Output
    // ========================================

    // After the last group the partial sum holds the complete product
    assign out_o.valid   = valid_p[CORE_STAGES];
    assign out_o.op      = op_p[CORE_STAGES];
    assign out_o.negate  = negate_p[CORE_STAGES];
    assign out_o.product = psum_p[CORE_STAGES];

endmodule : mul_array_core

//--- rtl/mul_operand_stage.sv
// Operand stage that decodes operand signedness, takes magnitudes and registers the item

`timescale 1ns/1ps

module mul_operand_stage
    import mul_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          clk_en_i,
    input  logic          clear_i,
    input  logic          valid_i,
    input  mul_uop_t      op_i,
    input  data_word_t    multiplicand_i,
    input  data_word_t    multiplier_i,
    mul_operand_if.src    out_o
);

    localparam int DW = $bits(data_word_t);

    // ========================================
    // Sign decode
    // ========================================

    // The multiplicand (rs1) is signed for everything but MULHU
    logic mcand_signed;
    // The multiplier (rs2) is signed only for MUL and MULH
    logic mplier_signed;

    assign mcand_signed  = (op_i != MULHU);
    assign mplier_signed = (op_i == MUL) || (op_i == MULH);

    // An operand needs a fix only when it is both signed and negative
    logic mcand_neg;
    logic mplier_neg;

    assign mcand_neg  = mcand_signed  & multiplicand_i[DW-1];
    assign mplier_neg = mplier_signed & multiplier_i[DW-1];

    // Magnitudes for the unsigned core
    // The most negative value maps onto itself, which read as unsigned is the right magnitude
    data_word_t mcand_mag;
    data_word_t mplier_mag;

    assign mcand_mag  = mcand_neg  ? (~multiplicand_i + 1'b1) : multiplicand_i;
    assign mplier_mag = mplier_neg ? (~multiplier_i + 1'b1)   : multiplier_i;

    // ========================================
    // Stage register
    // ========================================

    logic       valid_q;
    mul_uop_t   op_q;
    logic       negate_q;
    data_word_t mcand_q;
    data_word_t mplier_q;

    // The item's valid bit is dropped by reset and by the pipeline clear
    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (clk_en_i) begin
            valid_q <= valid_i;
        end
    end : valid_reg

    // Sign of the product differs from a plain unsigned one when exactly one side was negative
    always_ff @(posedge clk_i) begin : item_reg
        if (clk_en_i) begin
            op_q     <= op_i;
            negate_q <= mcand_neg ^ mplier_neg;
            mcand_q  <= mcand_mag;
            mplier_q <= mplier_mag;
        end
    end : item_reg

    assign out_o.valid        = valid_q;
    assign out_o.op           = op_q;
    assign out_o.negate       = negate_q;
    assign out_o.multiplicand = mcand_q;
    assign out_o.multiplier   = mplier_q;

endmodule : mul_operand_stage

//--- rtl/mul_pkg.sv
// Multiplier package with the data word, the double width product and the operation encoding

package mul_pkg;

    `include "mul_consts.svh"

    // ========================================
    // Data types
    // ========================================

    // One operand or one result word
    typedef logic [`MUL_DATA_WIDTH-1:0] data_word_t;

    // Full unsigned product of two magnitudes
    typedef logic [2*`MUL_DATA_WIDTH-1:0] product_t;

    // ========================================
    // Operation encoding
    // ========================================

    // RV32M multiply operations
    // MUL returns the low word and the other three return the high word
    // MULH is signed by signed and MULHSU is signed by unsigned
    // MULHU is unsigned by unsigned
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_uop_t;

endpackage : mul_pkg

//--- rtl/mul_result_stage.sv
// Result stage that registers the raw product, restores its sign and picks the result word

`timescale 1ns/1ps

module mul_result_stage
    import mul_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       clear_i,
    mul_product_if.dst in_i,
    output data_word_t product_o,
    output logic       valid_o
);

    localparam int DW = $bits(data_word_t);

    // ========================================
    // Product register
    // ========================================

    logic     valid_q;
    mul_uop_t op_q;
    logic     negate_q;
    product_t product_q;

    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (clk_en_i) begin
            valid_q <= in_i.valid;
        end
    end : valid_reg

    always_ff @(posedge clk_i) begin : product_reg
        if (clk_en_i) begin
            op_q      <= in_i.op;
            negate_q  <= in_i.negate;
            product_q <= in_i.product;
        end
    end : product_reg

    // ========================================
    // Sign restore and word select
    // ========================================

    // Two's complement of the full 64-bit product so the high word is right too
    product_t signed_product;

    assign signed_product = negate_q ? (~product_q + 1'b1) : product_q;

    // MUL keeps the low half and the high variants keep the upper half
    assign product_o = (op_q == MUL) ? signed_product[DW-1:0] : signed_product[2*DW-1:DW];

    assign valid_o = valid_q;

endmodule : mul_result_stage

//--- rtl/mul_stage_if.sv
// Stage-to-stage item interfaces of the multiplication pipeline

`timescale 1ns/1ps

// Item leaving the operand stage
// Operands are already magnitudes and negate tells the result stage to flip the sign
interface mul_operand_if
    import mul_pkg::*;
();

    logic       valid;
    mul_uop_t   op;
    logic       negate;
    data_word_t multiplicand;
    data_word_t multiplier;

    // Producer side
    modport src (output valid, op, negate, multiplicand, multiplier);

    // Consumer side
    modport dst (input valid, op, negate, multiplicand, multiplier);

endinterface : mul_operand_if


// Item leaving the array core with its raw unsigned product
interface mul_product_if
    import mul_pkg::*;
();

    logic     valid;
    mul_uop_t op;
    logic     negate;
    product_t product;

    // Producer side
    modport src (output valid, op, negate, product);

    // Consumer side
    modport dst (input valid, op, negate, product);

endinterface : mul_product_if

//--- rtl/multiplication_unit.sv
// Multiplication unit that runs RV32M multiplies through operand, array and result stages

`timescale 1ns/1ps

`include "mul_consts.svh"

module multiplication_unit
    import mul_pkg::*;
#(
    // Register depth of the array core
    // The total latency is CORE_STAGES + 2
    parameter int CORE_STAGES = `MUL_CORE_STAGES
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       clear_i,
    input  logic       valid_i,
    input  mul_uop_t   op_i,
    input  data_word_t multiplicand_i,
    input  data_word_t multiplier_i,
    output data_word_t product_o,
    output logic       valid_o
);

    // ========================================
    // Stage links
    // ========================================

    mul_operand_if operand_link ();
    mul_product_if product_link ();

    // ========================================
    // Pipeline
    // ========================================

    // Signed operands become magnitudes plus a negate flag
    mul_operand_stage u_operand_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .clear_i        (clear_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .out_o          (operand_link)
    );

    // Unsigned product over CORE_STAGES register groups
    mul_array_core #(
        .CORE_STAGES (CORE_STAGES)
    ) u_array_core (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .clear_i  (clear_i),
        .in_i     (operand_link),
        .out_o    (product_link)
    );

    // Sign restore and low or high word select
    mul_result_stage u_result_stage (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .clk_en_i  (clk_en_i),
        .clear_i   (clear_i),
        .in_i      (product_link),
        .product_o (product_o),
        .valid_o   (valid_o)
    );

endmodule : multiplication_unit

//--- run_sim.sh
#!/bin/sh
# Builds the multiplication unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_multiplication_unit
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o "sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints the fail message on any error or timeout
if grep -q "Done: errors found" "$LOG_FILE"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tb.f
+incdir+include
rtl/mul_pkg.sv
rtl/mul_stage_if.sv
rtl/mul_operand_stage.sv
rtl/mul_array_core.sv
rtl/mul_result_stage.sv
rtl/multiplication_unit.sv
tb/tb_multiplication_unit.sv

//--- tb/tb_multiplication_unit.sv
// Testbench for the multiplication unit that checks LFSR driven items against an RV32M model

`timescale 1ns/1ps

`include "mul_consts.svh"

module tb_multiplication_unit
    import mul_pkg::*;
();

    // ========================================
    // Run lengths
    // ========================================

    localparam int LATENCY        = `MUL_CORE_STAGES + 2;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 8;
    localparam int STREAM_ITEMS   = 2000;
    localparam int CORNER_ITEMS   = 4 * 5 * 5;
    localparam int GAP_CYCLES     = 1500;
    localparam int CLEAR_CYCLES   = 600;
    localparam int DRAIN_CYCLES   = LATENCY + 4;
    localparam int STIM_CYCLES    = RESET_CYCLES + IDLE_CYCLES + STREAM_ITEMS + CORNER_ITEMS
                                  + GAP_CYCLES + CLEAR_CYCLES + DRAIN_CYCLES + 1;
    localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + LATENCY);

    // One accepted item
    // Its tag is the count of enabled edges before it was taken
    typedef struct packed {
        mul_uop_t    op;
        data_word_t  value;
        logic [31:0] tag;
    } expect_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       clk_en_i;
    logic       clear_i;
    logic       valid_i;
    mul_uop_t   op_i;
    data_word_t multiplicand_i;
    data_word_t multiplier_i;
    data_word_t product_o;
    logic       valid_o;

    expect_t     expect_q [$];
    int          value_errors  = 0;
    int          other_errors  = 0;
    int          cycle_count   = 0;
    logic [31:0] lfsr_state    = 32'd60;
    logic [31:0] en_edges      = '0;
    logic        hold_pending  = 1'b0;
    logic        prev_valid    = 1'b0;
    data_word_t  prev_product  = '0;

    // Zero, one, all ones, most negative and most positive
    data_word_t corner_values [5] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                      32'h8000_0000, 32'h7FFF_FFFF};

    multiplication_unit dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .clear_i        (clear_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .product_o      (product_o),
        .valid_o        (valid_o)
    );

    // ========================================
    // Helpers
    // ========================================

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Collects count fresh bits and steps the LFSR once per bit
    function automatic data_word_t random_bits(input int count);
        data_word_t bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Reference result from 64-bit extension of each operand by the operation
    function automatic data_word_t model_result(input mul_uop_t op, input data_word_t a,
                                                input data_word_t b);
        logic [63:0] wide_a;
        logic [63:0] wide_b;
        logic [63:0] full;
        // rs1 is signed except in MULHU and rs2 is signed only in MUL and MULH
        wide_a = (op == MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
        wide_b = (op == MUL || op == MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        full   = wide_a * wide_b;
        return (op == MUL) ? full[31:0] : full[63:32];
    endfunction

    task automatic check_product(input mul_uop_t op, input data_word_t expected,
                                 input data_word_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: product_o (%s) expected %h, got %h",
                     $time, op.name(), expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: valid_o expected %b, got %b", $time, expected, actual);
            value_errors++;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic drive_cycle(input logic en, input logic clr, input logic vld,
                               input mul_uop_t op, input data_word_t a, input data_word_t b);
        @(posedge clk_i);
        #1;
        clk_en_i       = en;
        clear_i        = clr;
        valid_i        = vld;
        op_i           = op;
        multiplicand_i = a;
        multiplier_i   = b;
    endtask

    task automatic drive_random(input logic en, input logic clr, input logic vld);
        data_word_t op_bits;
        data_word_t a;
        data_word_t b;
        op_bits = random_bits(2);
        a       = random_bits(32);
        b       = random_bits(32);
        drive_cycle(en, clr, vld, mul_uop_t'(op_bits[1:0]), a, b);
    endtask

    // ========================================
    // Clock, watchdog and output monitor
    // ========================================

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // Mid-cycle sampling sees settled outputs and the inputs for the coming edge
    always @(negedge clk_i) begin : monitor
        expect_t front;
        expect_t item;
        logic    due;
        if (rst_n_i) begin
            // A disabled edge without clear must leave the outputs untouched
            if (hold_pending) begin
                check_valid(prev_valid, valid_o);
                if (prev_valid && expect_q.size() > 0) begin
                    check_product(expect_q[0].op, prev_product, product_o);
                end
            end
            // An output counts as taken only at an enabled edge
            if (clk_en_i) begin
                if (expect_q.size() == 0) begin
                    if (valid_o) begin
                        $display("Unexpected output at %0t: valid_o high with no item in flight",
                                 $time);
                        other_errors++;
                    end
                end else begin
                    front = expect_q[0];
                    due   = (en_edges - front.tag) >= LATENCY;
                    check_valid(due, valid_o);
                    if (due || valid_o) begin
                        front = expect_q.pop_front();
                        if (valid_o) begin
                            check_product(front.op, front.value, product_o);
                        end
                    end
                end
            end
            // Clear drops everything in flight and the item offered with it
            if (clear_i) begin
                expect_q.delete();
            end else if (clk_en_i && valid_i) begin
                item.op    = op_i;
                item.value = model_result(op_i, multiplicand_i, multiplier_i);
                item.tag   = en_edges;
                expect_q.push_back(item);
            end
            if (clk_en_i) begin
                en_edges++;
            end
            hold_pending = !clk_en_i && !clear_i;
            prev_valid   = valid_o;
            prev_product = product_o;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin : stimulus
        logic en;
        logic clr;
        logic vld;
        rst_n_i        = 1'b0;
        clk_en_i       = 1'b1;
        clear_i        = 1'b0;
        valid_i        = 1'b0;
        op_i           = MUL;
        multiplicand_i = '0;
        multiplier_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Nothing may come out before the first input
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            check_valid(1'b0, valid_o);
        end

        // Back to back items with the enable held high
        repeat (STREAM_ITEMS) begin
            drive_random(1'b1, 1'b0, 1'b1);
        end

        // Every pair of corner operands in every operation
        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    drive_cycle(1'b1, 1'b0, 1'b1, mul_uop_t'(o), corner_values[i],
                                corner_values[j]);
                end
            end
        end

        // Enable is low about a quarter of the time and some inputs are idle
        repeat (GAP_CYCLES) begin
            en  = (random_bits(2) != 0);
            vld = (random_bits(3) != 0);
            drive_random(en, 1'b0, vld);
        end

        // Occasional clear pulses with the pipeline busy
        repeat (CLEAR_CYCLES) begin
            en  = (random_bits(3) != 0);
            clr = (random_bits(5) == 0);
            drive_random(en, clr, 1'b1);
        end

        // Let the last items drain out
        repeat (DRAIN_CYCLES) begin
            drive_cycle(1'b1, 1'b0, 1'b0, MUL, '0, '0);
        end
        @(negedge clk_i);
        #1;

        if (expect_q.size() != 0) begin
            $display("Items lost: %0d accepted items never reached the output", expect_q.size());
            other_errors++;
        end
        $display("Summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_multiplication_unit
